//--- verilog/mips_cfg.svh
/* widths, data memory depth and MIPS encodings of the pipeline
   included by the package and by RTL files that decode or size storage */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

`define MIPS_WORD_W       32
`define MIPS_REG_ADDR_W   5
`define MIPS_REG_COUNT    32
`define MIPS_DMEM_WORDS   64
`define MIPS_DMEM_ADDR_W  6     // log2 of the data memory depth

`define MIPS_OP_RTYPE     6'h00
`define MIPS_OP_ADDI      6'h08
`define MIPS_OP_LW        6'h23
`define MIPS_OP_SW        6'h2b
`define MIPS_OP_BEQ       6'h04
`define MIPS_OP_BNE       6'h05
`define MIPS_OP_J         6'h02

`define MIPS_FN_ADD       6'h20
`define MIPS_FN_SUB       6'h22
`define MIPS_FN_AND       6'h24
`define MIPS_FN_OR        6'h25
`define MIPS_FN_SLT       6'h2a

`endif

//--- verilog/mips_pkg.sv
/* types shared by the pipeline stages
   modules refer to them as mips_pkg::name */
`include "mips_cfg.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0]     word_t;      // register and memory data
    typedef logic [`MIPS_WORD_W-1:0]     instr_t;     // raw instruction word
    typedef logic [`MIPS_WORD_W-1:0]     pc_t;        // byte address
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;  // register index

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

endpackage

//--- verilog/register_file.sv
/* 32 x 32 register file, two read ports and one write port
   same-cycle writes pass through to the reads; r0 is always zero */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module register_file (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    input  logic                wr_en,
    input  mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     wr_data
);
    mips_pkg::word_t regs [`MIPS_REG_COUNT];
    logic            wr_live;

    assign wr_live = wr_en && (wr_addr != '0);   // writes to r0 dropped

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wr_live)
            regs[wr_addr] <= wr_data;
    end

    assign rs_data = (rs_addr == '0) ? '0 :
                     (wr_live && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (wr_live && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

//--- verilog/fetch_stage.sv
/* program counter and the fetch/decode pipeline register
   holds on stall, loads a nop behind a taken branch or jump */
`timescale 1ns/1ps

module fetch_stage (
    input  logic             SYS_clk,
    input  logic             SYS_reset,
    input  logic             stall,
    input  logic             redirect,
    input  mips_pkg::pc_t    redirect_pc,
    input  mips_pkg::instr_t imem_data,
    output mips_pkg::pc_t    imem_addr,
    output mips_pkg::instr_t dec_instr,
    output mips_pkg::pc_t    dec_pc
);
    mips_pkg::pc_t pc;

    assign imem_addr = pc;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            pc        <= '0;
            dec_instr <= '0;               // nop
        end
        else if (!stall)
        begin
            if (redirect)
            begin
                pc        <= redirect_pc;
                dec_instr <= '0;           // squash the wrong-path word
            end
            else
            begin
                pc        <= pc + 32'd4;
                dec_instr <= imem_data;
            end
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
            dec_pc <= pc;                  // base for branch and jump targets
    end

endmodule

//--- verilog/decode_stage.sv
/* decode: control levels, sign extension, register read and hazard stall
   beq, bne and j resolve here and redirect fetch */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module decode_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::instr_t    dec_instr,
    input  mips_pkg::pc_t       dec_pc,
    input  logic                ex_reg_write,
    input  logic                mem_reg_write,
    input  mips_pkg::reg_addr_t ex_dest_reg,
    input  mips_pkg::reg_addr_t mem_dest_reg,
    input  logic                wb_write_en,
    input  mips_pkg::reg_addr_t wb_write_reg,
    input  mips_pkg::word_t     wb_write_data,
    output logic                stall,
    output logic                redirect,
    output mips_pkg::pc_t       redirect_pc,
    output logic                reg_write,
    output logic                mem_read,
    output logic                mem_write,
    output logic                mem_to_reg,
    output logic                alu_src,
    output logic                is_rtype,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     imm,
    output logic [5:0]          funct,
    output mips_pkg::reg_addr_t dest_reg
);
    logic [5:0]          opcode;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    logic                op_rtype;
    logic                op_addi;
    logic                op_lw;
    logic                op_sw;
    logic                op_beq;
    logic                op_bne;
    logic                op_j;
    logic                rs_busy;
    logic                rt_busy;
    logic                take_branch;

    assign opcode = dec_instr[31:26];
    assign rs     = dec_instr[25:21];
    assign rt     = dec_instr[20:16];
    assign rd     = dec_instr[15:11];
    assign funct  = dec_instr[5:0];

    assign op_rtype = (opcode == `MIPS_OP_RTYPE);
    assign op_addi  = (opcode == `MIPS_OP_ADDI);
    assign op_lw    = (opcode == `MIPS_OP_LW);
    assign op_sw    = (opcode == `MIPS_OP_SW);
    assign op_beq   = (opcode == `MIPS_OP_BEQ);
    assign op_bne   = (opcode == `MIPS_OP_BNE);
    assign op_j     = (opcode == `MIPS_OP_J);

    register_file i_regs (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (rs),
        .rt_addr   (rt),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .wr_en     (wb_write_en),
        .wr_addr   (wb_write_reg),
        .wr_data   (wb_write_data)
    );

    // a source is busy while an older writer sits in execute or memory
    assign rs_busy = (rs != '0) && ((ex_reg_write && ex_dest_reg == rs) ||
                                    (mem_reg_write && mem_dest_reg == rs));
    assign rt_busy = (rt != '0) && ((ex_reg_write && ex_dest_reg == rt) ||
                                    (mem_reg_write && mem_dest_reg == rt));

    assign stall = (rs_busy && (op_rtype || op_addi || op_lw || op_sw || op_beq || op_bne))
                || (rt_busy && (op_rtype || op_sw || op_beq || op_bne));

    assign imm      = {{16{dec_instr[15]}}, dec_instr[15:0]};
    assign dest_reg = op_rtype ? rd : rt;

    // bubble on stall, unknown opcodes leave every level low
    assign reg_write  = !stall && (op_rtype || op_addi || op_lw);
    assign mem_read   = !stall && op_lw;
    assign mem_write  = !stall && op_sw;
    assign mem_to_reg = !stall && op_lw;
    assign alu_src    = !stall && (op_addi || op_lw || op_sw);
    assign is_rtype   = !stall && op_rtype;

    assign take_branch = (op_beq && rs_data == rt_data) || (op_bne && rs_data != rt_data);
    assign redirect    = !stall && (take_branch || op_j);
    assign redirect_pc = op_j ? {dec_pc[31:28], dec_instr[25:0], 2'b00}
                              : dec_pc + 32'd4 + (imm << 2);

endmodule

//--- verilog/execute_stage.sv
/* decode/execute pipeline register and the ALU
   R-type picks its operation from funct, everything else adds */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module execute_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                reg_write,
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic                mem_to_reg,
    input  logic                alu_src,
    input  logic                is_rtype,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    input  mips_pkg::word_t     imm,
    input  logic [5:0]          funct,
    input  mips_pkg::reg_addr_t dest_reg,
    output logic                ex_reg_write,
    output logic                ex_mem_read,
    output logic                ex_mem_write,
    output logic                ex_mem_to_reg,
    output mips_pkg::reg_addr_t ex_dest_reg,
    output mips_pkg::word_t     ex_alu_result,
    output mips_pkg::word_t     ex_store_data
);
    logic              ex_alu_src;
    logic              ex_is_rtype;
    mips_pkg::word_t   ex_rs;
    mips_pkg::word_t   ex_imm;
    logic [5:0]        ex_funct;
    mips_pkg::word_t   operand_b;
    mips_pkg::alu_op_t alu_op;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            ex_reg_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_alu_src    <= 1'b0;
            ex_is_rtype   <= 1'b0;
        end
        else
        begin
            ex_reg_write  <= reg_write;
            ex_mem_read   <= mem_read;
            ex_mem_write  <= mem_write;
            ex_mem_to_reg <= mem_to_reg;
            ex_alu_src    <= alu_src;
            ex_is_rtype   <= is_rtype;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_rs         <= rs_data;
        ex_store_data <= rt_data;           // rt, also the store value
        ex_imm        <= imm;
        ex_funct      <= funct;
        ex_dest_reg   <= dest_reg;
    end

    always_comb
    begin
        alu_op = mips_pkg::ALU_ADD;         // addi, lw, sw address
        if (ex_is_rtype)
        begin
            case (ex_funct)
                `MIPS_FN_ADD: alu_op = mips_pkg::ALU_ADD;
                `MIPS_FN_SUB: alu_op = mips_pkg::ALU_SUB;
                `MIPS_FN_AND: alu_op = mips_pkg::ALU_AND;
                `MIPS_FN_OR:  alu_op = mips_pkg::ALU_OR;
                `MIPS_FN_SLT: alu_op = mips_pkg::ALU_SLT;
                default:      alu_op = mips_pkg::ALU_ADD;
            endcase
        end
    end

    assign operand_b = ex_alu_src ? ex_imm : ex_store_data;

    always_comb
    begin
        case (alu_op)
            mips_pkg::ALU_SUB: ex_alu_result = ex_rs - operand_b;
            mips_pkg::ALU_AND: ex_alu_result = ex_rs & operand_b;
            mips_pkg::ALU_OR:  ex_alu_result = ex_rs | operand_b;
            mips_pkg::ALU_SLT: ex_alu_result = ($signed(ex_rs) < $signed(operand_b)) ? 32'd1 : 32'd0;
            default:           ex_alu_result = ex_rs + operand_b;
        endcase
    end

endmodule

//--- verilog/memory_stage.sv
/* execute/memory register, word-addressed data memory and the
   memory/writeback register with its result mux */
`timescale 1ns/1ps
`include "mips_cfg.svh"

module memory_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  logic                ex_mem_write,
    input  logic                ex_mem_to_reg,
    input  mips_pkg::reg_addr_t ex_dest_reg,
    input  mips_pkg::word_t     ex_alu_result,
    input  mips_pkg::word_t     ex_store_data,
    output logic                mem_reg_write,
    output mips_pkg::reg_addr_t mem_dest_reg,
    output logic                wb_write_en,
    output mips_pkg::reg_addr_t wb_write_reg,
    output mips_pkg::word_t     wb_write_data
);
    logic                         m_mem_read;
    logic                         m_mem_write;
    logic                         m_mem_to_reg;
    mips_pkg::word_t              m_alu_result;
    mips_pkg::word_t              m_store_data;
    mips_pkg::word_t              dmem [`MIPS_DMEM_WORDS];
    logic [`MIPS_DMEM_ADDR_W-1:0] dmem_idx;
    logic                         wb_mem_to_reg;
    mips_pkg::word_t              wb_load_data;
    mips_pkg::word_t              wb_alu_result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_reg_write <= 1'b0;
            m_mem_read    <= 1'b0;
            m_mem_write   <= 1'b0;
            m_mem_to_reg  <= 1'b0;
            wb_write_en   <= 1'b0;
            wb_mem_to_reg <= 1'b0;
        end
        else
        begin
            mem_reg_write <= ex_reg_write;
            m_mem_read    <= ex_mem_read;
            m_mem_write   <= ex_mem_write;
            m_mem_to_reg  <= ex_mem_to_reg;
            wb_write_en   <= mem_reg_write && (mem_dest_reg != '0);  // r0 never retires
            wb_mem_to_reg <= m_mem_to_reg;
        end
    end

    assign dmem_idx = m_alu_result[`MIPS_DMEM_ADDR_W+1:2];   // byte addr to word, wraps

    always_ff @(posedge SYS_clk)
    begin
        mem_dest_reg  <= ex_dest_reg;
        m_alu_result  <= ex_alu_result;
        m_store_data  <= ex_store_data;
        wb_write_reg  <= mem_dest_reg;
        wb_alu_result <= m_alu_result;
        if (m_mem_write)
            dmem[dmem_idx] <= m_store_data;
        if (m_mem_read)
            wb_load_data <= dmem[dmem_idx];   // sees a store made one cycle earlier
    end

    assign wb_write_data = wb_mem_to_reg ? wb_load_data : wb_alu_result;

endmodule

//--- verilog/mips_core.sv
/* five-stage MIPS integer pipeline, top level
   instruction memory sits outside; retiring writebacks show on the wb ports */
`timescale 1ns/1ps

module mips_core (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    output mips_pkg::pc_t       imem_addr,
    input  mips_pkg::instr_t    imem_data,
    output logic                wb_write_en,
    output mips_pkg::reg_addr_t wb_write_reg,
    output mips_pkg::word_t     wb_write_data
);
    // fetch <-> decode
    logic                stall;
    logic                redirect;
    mips_pkg::pc_t       redirect_pc;
    mips_pkg::instr_t    dec_instr;
    mips_pkg::pc_t       dec_pc;

    // decode -> execute
    logic                reg_write;
    logic                mem_read;
    logic                mem_write;
    logic                mem_to_reg;
    logic                alu_src;
    logic                is_rtype;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    mips_pkg::word_t     imm;
    logic [5:0]          funct;
    mips_pkg::reg_addr_t dest_reg;

    // execute -> memory, also back to decode
    logic                ex_reg_write;
    logic                ex_mem_read;
    logic                ex_mem_write;
    logic                ex_mem_to_reg;
    mips_pkg::reg_addr_t ex_dest_reg;
    mips_pkg::word_t     ex_alu_result;
    mips_pkg::word_t     ex_store_data;

    // memory -> decode hazard check
    logic                mem_reg_write;
    mips_pkg::reg_addr_t mem_dest_reg;

    fetch_stage i_fetch (
        .*
    );

    decode_stage i_decode (
        .*
    );

    execute_stage i_execute (
        .*
    );

    memory_stage i_memory (
        .*
    );

endmodule

//--- tests/mips_core_tb.sv
/* testbench that loads each program for the five-stage MIPS core from the cases file,
   serves instruction memory and checks the retiring writebacks in order */
`timescale 1ns/1ps

module mips_core_tb;

    logic        SYS_clk;
    logic        SYS_reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        wb_write_en;
    logic [4:0]  wb_write_reg;
    logic [31:0] wb_write_data;

    logic [31:0] imem [0:255];
    string       test_names [0:15];
    int          prog_start [0:15];
    int          prog_len [0:15];
    logic [31:0] prog_words [0:511];
    logic [4:0]  exp_reg [0:511];    // 0 means the instruction must not retire a write
    logic [31:0] exp_val [0:511];
    int          n_tests;
    int          n_words;
    bit          cases_loaded;
    string       cur_name;

    mips_core i_dut (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .wb_write_en   (wb_write_en),
        .wb_write_reg  (wb_write_reg),
        .wb_write_data (wb_write_data)
    );

    // combinational instruction memory that reads zero past the program
    assign imem_data = (imem_addr[31:10] == '0) ? imem[imem_addr[9:2]] : 32'd0;

    initial
    begin
        SYS_clk = 1'b0;
        forever #2 SYS_clk = ~SYS_clk;
    end

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("FAIL %s %s: expected %h, actual %h", cur_name, what, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic expect_no_writeback(string when);
        assert (wb_write_en === 1'b0)
        else
        begin
            $display("test %s: a writeback appeared %s", cur_name, when);
            $display("*** TEST FAILED ***");
            $fatal(1, "unexpected writeback");
        end
    endtask

    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        string       key;
        string       name_str;
        logic [31:0] word;
        int          r;
        logic [31:0] val;
        fd = $fopen("tests/mips_cases.txt", "r");
        if (fd == 0)
        begin
            $display("the cases file could not be opened");
            $display("*** TEST FAILED ***");
            $fatal(1, "no cases file");
        end
        n_tests = 0;
        n_words = 0;
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%s", key);
            if (n < 1 || key.substr(0, 0) == "#")
                continue;
            if (key == "test")
            begin
                void'($sscanf(line, "%s %s", key, name_str));
                test_names[n_tests] = name_str;
                prog_start[n_tests] = n_words;
                prog_len[n_tests]   = 0;
                n_tests++;
            end
            else if ($sscanf(line, "%h %d %h", word, r, val) == 3)
            begin
                prog_words[n_words] = word;
                exp_reg[n_words]    = r[4:0];
                exp_val[n_words]    = val;
                n_words++;
                prog_len[n_tests-1]++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(int t);
        int idle;
        int idx;
        int last;
        cur_name = test_names[t];
        @(posedge SYS_clk);
        SYS_reset <= 1'b1;
        for (int i = 0; i < 256; i++)
            imem[i] <= (i < prog_len[t]) ? prog_words[prog_start[t] + i] : 32'd0;
        for (int c = 0; c < 3; c++)
        begin
            @(negedge SYS_clk);
            expect_no_writeback("during reset");
        end
        check_value("pc after reset", 32'd0, imem_addr);
        @(posedge SYS_clk);
        SYS_reset <= 1'b0;
        idle = $urandom_range(2, 0);
        repeat (idle)
        begin
            @(negedge SYS_clk);
            expect_no_writeback("before the first instruction could retire");
        end
        idx  = prog_start[t];
        last = prog_start[t] + prog_len[t];
        while (idx < last)
        begin
            if (exp_reg[idx] == '0)
                idx++;                            // squashed, store, branch or r0 write
            else
            begin
                @(negedge SYS_clk);
                if (wb_write_en)
                begin
                    check_value($sformatf("reg of word %0d", idx - prog_start[t]),
                                {27'd0, exp_reg[idx]}, {27'd0, wb_write_reg});
                    check_value($sformatf("data of word %0d", idx - prog_start[t]),
                                exp_val[idx], wb_write_data);
                    idx++;
                end
            end
        end
        repeat (16)
        begin
            @(negedge SYS_clk);
            expect_no_writeback("after the last expected one");
        end
    endtask

    // watchdog budget grows with program length
    initial
    begin
        int limit;
        wait (cases_loaded);
        limit = n_words * 5 + n_tests * 32 + 100;
        repeat (limit) @(posedge SYS_clk);
        $display("timeout: the writebacks of test %s did not all appear", cur_name);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        SYS_reset    = 1'b1;
        cases_loaded = 0;
        cur_name     = "load";
        void'($urandom(32'hcf49_175e));
        read_cases();
        cases_loaded = 1;
        for (int t = 0; t < n_tests; t++)
            run_test(t);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- build.f
+incdir+verilog
verilog/mips_pkg.sv
verilog/register_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/mips_core.sv
tests/mips_core_tb.sv

//--- tests/mips_cases.txt
# each group: a "test <name>" line, then one line per instruction word
# columns: instruction (hex), expected writeback register (0 = none), expected value (hex)
test alu
20010005 1 00000005
2002fffd 2 fffffffd
00221820 3 00000002
00222022 4 00000008
00222824 5 00000005
00223025 6 fffffffd
0041382a 7 00000001
0022402a 8 00000000
test mem
20010077 1 00000077
20020008 2 00000008
ac410000 0 00000000
8c430000 3 00000077
2004ffff 4 ffffffff
ac440004 0 00000000
8c450004 5 ffffffff
8c460000 6 00000077
8c470100 7 00000077
test hazard
2001000a 1 0000000a
20220001 2 0000000b
20060007 6 00000007
20090002 9 00000002
00c04022 8 00000007
200a0064 10 00000064
200b0003 11 00000003
200c0004 12 00000004
014b6825 13 00000067
test branch
20010004 1 00000004
20020004 2 00000004
10220002 0 00000000
20030063 0 00000000
20030062 0 00000000
14220001 0 00000000
20040001 4 00000001
14240001 0 00000000
20050037 0 00000000
10240001 0 00000000
0800000c 0 00000000
20060042 0 00000000
20070007 7 00000007
00e14020 8 0000000b
test zero
20000005 0 00000000
20010003 1 00000003
00210020 0 00000000
00011020 2 00000003
fc1f0000 0 00000000
